//--- lc3b_types.sv
package lc3b_types;

	// Byte address as the processor sees it.
	typedef logic [15:0] lc3b_word;

	// Line address is the byte address without its low four bits.
	typedef logic [11:0] lc3b_line_addr;

	// One cache line of 16 bytes.
	typedef logic [127:0] lc3b_line;

	// One select bit per byte of the line.
	typedef logic [15:0] lc3b_sel;

	// Wishbone classic master to slave signals.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		lc3b_line_addr adr;
		lc3b_sel sel;
		lc3b_line dat;
	} wb_req_t;

	// Wishbone classic slave to master signals.
	typedef struct packed {
		logic ack;
		logic rty; // Held low by the cache on the CPU side.
		lc3b_line dat;
	} wb_resp_t;

	// Controller states.
	typedef enum logic [1:0] {
		idle,
		compare,
		writeback,
		refill
	} cache_state_t;

endpackage: lc3b_types

//--- cache_array.sv
module cache_array #(
	parameter int set_count = 8,
	localparam int index_w = $clog2(set_count),
	localparam int tag_w = $bits(lc3b_types::lc3b_line_addr) - index_w
) (
	input logic clk,
	input logic arst_n,
	input logic [index_w-1:0] index,
	input logic write,
	input logic valid_in,
	input logic dirty_in,
	input logic [tag_w-1:0] tag_in,
	input lc3b_types::lc3b_line line_in,
	output logic valid,
	output logic dirty,
	output logic [tag_w-1:0] tag,
	output lc3b_types::lc3b_line line
);

	// Status bits per set.
	logic [set_count-1:0] valid_bits;
	logic [set_count-1:0] dirty_bits;

	// Tag and data storage, one entry per set.
	logic [tag_w-1:0] tags [set_count];
	lc3b_types::lc3b_line lines [set_count];

	// Status bits must come up clear so that nothing hits after reset.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (write) begin
			valid_bits[index] <= valid_in;
			dirty_bits[index] <= dirty_in;
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[index] <= tag_in;
			lines[index] <= line_in;
		end
	end

	// Reads are combinational from the index.
	assign valid = valid_bits[index];
	assign dirty = dirty_bits[index];
	assign tag = tags[index];
	assign line = lines[index];

endmodule: cache_array

//--- cache_datapath.sv
module cache_datapath #(
	parameter int set_count = 8
) (
	input logic clk,
	input logic arst_n,
	input lc3b_types::wb_req_t cpu_req,
	input lc3b_types::lc3b_line mem_line,
	input logic load_line,
	input logic line_src,
	input logic fill_way,
	input logic set_dirty,
	input logic set_lru,
	input logic mem_addr_src,
	output logic hit,
	output logic hit_way,
	output logic victim_dirty,
	output lc3b_types::lc3b_line cpu_line,
	output lc3b_types::lc3b_line_addr mem_adr,
	output lc3b_types::lc3b_line victim_line
);

	localparam int index_w = $clog2(set_count);
	localparam int tag_w = $bits(lc3b_types::lc3b_line_addr) - index_w;

	logic [index_w-1:0] index;
	logic [tag_w-1:0] req_tag;

	logic [1:0] way_valid;
	logic [1:0] way_dirty;
	logic [1:0] way_write;
	logic [1:0] way_match;
	logic [tag_w-1:0] way_tag [2];
	lc3b_types::lc3b_line way_line [2];

	// One bit per set naming the way to evict next.
	logic [set_count-1:0] lru;
	logic victim;
	logic write_way;

	lc3b_types::lc3b_line base_line;
	lc3b_types::lc3b_line new_line;

	assign index = cpu_req.adr[index_w-1:0];
	assign req_tag = cpu_req.adr[$bits(lc3b_types::lc3b_line_addr)-1:index_w];

	cache_array #(.set_count(set_count)) i_way0 (
		.clk(clk),
		.arst_n(arst_n),
		.index(index),
		.write(way_write[0]),
		.valid_in(1'b1),
		.dirty_in(set_dirty),
		.tag_in(req_tag),
		.line_in(new_line),
		.valid(way_valid[0]),
		.dirty(way_dirty[0]),
		.tag(way_tag[0]),
		.line(way_line[0])
	);

	cache_array #(.set_count(set_count)) i_way1 (
		.clk(clk),
		.arst_n(arst_n),
		.index(index),
		.write(way_write[1]),
		.valid_in(1'b1),
		.dirty_in(set_dirty),
		.tag_in(req_tag),
		.line_in(new_line),
		.valid(way_valid[1]),
		.dirty(way_dirty[1]),
		.tag(way_tag[1]),
		.line(way_line[1])
	);

	assign way_match[0] = way_valid[0] && (way_tag[0] == req_tag);
	assign way_match[1] = way_valid[1] && (way_tag[1] == req_tag);

	assign victim = lru[index];
	assign hit = |way_match;
	assign hit_way = hit ? way_match[1] : victim; // On a miss this names the way to replace.

	// An invalid victim never needs a write-back.
	assign victim_dirty = way_valid[victim] && way_dirty[victim];
	assign victim_line = way_line[victim];
	assign cpu_line = way_line[hit_way];

	// Memory fills go to the way the controller latched at the miss.
	assign write_way = line_src ? fill_way : hit_way;
	assign way_write[0] = load_line && !write_way;
	assign way_write[1] = load_line && write_way;

	assign base_line = line_src ? mem_line : way_line[hit_way];

	// A write miss merges the CPU bytes into the refilled line as well.
	always_comb begin
		new_line = base_line;
		for (int i = 0; i < $bits(lc3b_types::lc3b_sel); i++) begin
			if (cpu_req.we && cpu_req.sel[i])
				new_line[i*8 +: 8] = cpu_req.dat[i*8 +: 8];
		end
	end

	assign mem_adr = mem_addr_src ? {way_tag[victim], index} : cpu_req.adr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lru <= '0;
		else if (set_lru)
			lru[index] <= ~hit_way; // Point away from the way just used.
	end

endmodule: cache_datapath

//--- cache_control.sv
module cache_control (
	input logic clk,
	input logic arst_n,
	input logic cpu_cyc,
	input logic cpu_stb,
	input logic cpu_we,
	input logic hit,
	input logic hit_way,
	input logic victim_dirty,
	input logic mem_ack,
	input logic mem_rty,
	output logic cpu_ack,
	output logic mem_cyc,
	output logic mem_stb,
	output logic mem_we,
	output logic load_line,
	output logic line_src,
	output logic fill_way,
	output logic set_dirty,
	output logic set_lru,
	output logic mem_addr_src
);

	lc3b_types::cache_state_t state;
	lc3b_types::cache_state_t state_next;

	logic cpu_live;
	logic mem_done;
	logic mem_retry;
	logic ack_next;
	logic mem_stb_next;

	assign cpu_live = cpu_cyc && cpu_stb;
	assign mem_done = mem_stb && mem_ack;
	assign mem_retry = mem_stb && mem_rty;

	always_comb begin
		state_next = state;
		ack_next = 1'b0;
		mem_stb_next = 1'b0;
		case (state)
			lc3b_types::idle: begin
				// The strobe is still up during our own ack cycle.
				if (cpu_live && !cpu_ack)
					state_next = lc3b_types::compare;
			end
			lc3b_types::compare: begin
				if (!cpu_live) begin
					state_next = lc3b_types::idle;
				end else if (hit) begin
					ack_next = 1'b1;
					state_next = lc3b_types::idle;
				end else begin
					mem_stb_next = 1'b1;
					if (victim_dirty)
						state_next = lc3b_types::writeback;
					else
						state_next = lc3b_types::refill;
				end
			end
			lc3b_types::writeback, lc3b_types::refill: begin
				if (mem_done) begin
					if (state == lc3b_types::writeback)
						state_next = lc3b_types::refill;
					else
						state_next = lc3b_types::compare;
				end else if (!mem_retry) begin
					mem_stb_next = 1'b1; // Also raises the strobe again after a gap.
				end
			end
			default: state_next = lc3b_types::idle;
		endcase
	end

	// Array and LRU controls for the current state.
	always_comb begin
		load_line = 1'b0;
		line_src = 1'b0;
		set_dirty = 1'b0;
		set_lru = 1'b0;
		case (state)
			lc3b_types::compare: begin
				if (cpu_live && hit) begin
					set_lru = 1'b1;
					load_line = cpu_we;
					set_dirty = cpu_we;
				end
			end
			lc3b_types::refill: begin
				if (mem_done) begin
					load_line = 1'b1;
					line_src = 1'b1;
					set_dirty = cpu_we; // Write misses merge during the fill.
				end
			end
			default: begin
				load_line = 1'b0;
			end
		endcase
	end

	assign mem_addr_src = (state == lc3b_types::writeback);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= lc3b_types::idle;
			cpu_ack <= 1'b0;
			mem_cyc <= 1'b0;
			mem_stb <= 1'b0;
			mem_we <= 1'b0;
			fill_way <= 1'b0;
		end else begin
			state <= state_next;
			cpu_ack <= ack_next;
			mem_cyc <= mem_stb_next;
			mem_stb <= mem_stb_next;
			mem_we <= (state_next == lc3b_types::writeback);
			// Hold the victim way for the whole miss.
			if (state == lc3b_types::compare && !hit)
				fill_way <= hit_way;
		end
	end

endmodule: cache_control

//--- cache.sv
module cache #(
	parameter int set_count = 8
) (
	input logic clk,
	input logic arst_n,
	input lc3b_types::wb_req_t cpu_req,
	output lc3b_types::wb_resp_t cpu_resp,
	output lc3b_types::wb_req_t mem_req,
	input lc3b_types::wb_resp_t mem_resp
);

	logic hit;
	logic hit_way;
	logic victim_dirty;
	logic load_line;
	logic line_src;
	logic fill_way;
	logic set_dirty;
	logic set_lru;
	logic mem_addr_src;

	assign cpu_resp.rty = 1'b0; // The CPU is only stalled through a late ack.
	assign mem_req.sel = '1; // Memory always moves whole lines.

	cache_datapath #(.set_count(set_count)) i_datapath (
		.clk(clk),
		.arst_n(arst_n),
		.cpu_req(cpu_req),
		.mem_line(mem_resp.dat),
		.load_line(load_line),
		.line_src(line_src),
		.fill_way(fill_way),
		.set_dirty(set_dirty),
		.set_lru(set_lru),
		.mem_addr_src(mem_addr_src),
		.hit(hit),
		.hit_way(hit_way),
		.victim_dirty(victim_dirty),
		.cpu_line(cpu_resp.dat),
		.mem_adr(mem_req.adr),
		.victim_line(mem_req.dat)
	);

	cache_control i_control (
		.clk(clk),
		.arst_n(arst_n),
		.cpu_cyc(cpu_req.cyc),
		.cpu_stb(cpu_req.stb),
		.cpu_we(cpu_req.we),
		.hit(hit),
		.hit_way(hit_way),
		.victim_dirty(victim_dirty),
		.mem_ack(mem_resp.ack),
		.mem_rty(mem_resp.rty),
		.cpu_ack(cpu_resp.ack),
		.mem_cyc(mem_req.cyc),
		.mem_stb(mem_req.stb),
		.mem_we(mem_req.we),
		.load_line(load_line),
		.line_src(line_src),
		.fill_way(fill_way),
		.set_dirty(set_dirty),
		.set_lru(set_lru),
		.mem_addr_src(mem_addr_src)
	);

endmodule: cache

//--- cache_mem_model.sv
module cache_mem_model (
	input logic clk,
	input logic arst_n,
	input lc3b_types::wb_req_t req,
	output lc3b_types::wb_resp_t resp
);

	// Only lines that were written back are stored.
	lc3b_types::lc3b_line store [lc3b_types::lc3b_line_addr];

	int access_count;
	int retry_count;
	logic busy;
	logic [1:0] wait_left;
	logic [31:0] rand_state;
	logic [31:0] roll;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Every 16-bit word of an unwritten line holds the line address.
	function automatic lc3b_types::lc3b_line default_line(input lc3b_types::lc3b_line_addr adr);
		return {8{4'h0, adr}};
	endfunction

	task complete_access();
		lc3b_types::lc3b_line line_data;
		resp.ack <= 1'b1;
		busy <= 1'b0;
		access_count <= access_count + 1;
		if (store.exists(req.adr))
			line_data = store[req.adr];
		else
			line_data = default_line(req.adr);
		if (req.we) begin
			// Only the selected bytes of a write reach the stored line.
			for (int i = 0; i < $bits(lc3b_types::lc3b_sel); i++) begin
				if (req.sel[i])
					line_data[i*8 +: 8] = req.dat[i*8 +: 8];
			end
			store[req.adr] = line_data;
		end else begin
			resp.dat <= line_data;
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp <= '0;
			busy <= 1'b0;
			wait_left <= '0;
			access_count <= 0;
			retry_count <= 0;
			rand_state <= 32'd4;
		end else if (resp.ack || resp.rty) begin
			resp.ack <= 1'b0; // Both are single-cycle pulses.
			resp.rty <= 1'b0;
		end else if (req.cyc && req.stb) begin
			if (busy) begin
				if (wait_left == 2'd0)
					complete_access();
				else
					wait_left <= wait_left - 2'd1;
			end else begin
				roll = xorshift(rand_state);
				rand_state <= roll;
				if (roll[2:0] == 3'd0) begin
					resp.rty <= 1'b1; // Roughly one access in eight.
					retry_count <= retry_count + 1;
				end else if (roll[4:3] == 2'd0) begin
					complete_access();
				end else begin
					busy <= 1'b1;
					wait_left <= roll[4:3] - 2'd1;
				end
			end
		end
	end

endmodule: cache_mem_model

//--- cache_sva.sv
module cache_sva (
	input logic clk,
	input logic arst_n,
	input lc3b_types::wb_req_t cpu_req,
	input lc3b_types::wb_resp_t cpu_resp,
	input lc3b_types::wb_req_t mem_req,
	input lc3b_types::wb_resp_t mem_resp,
	input lc3b_types::cache_state_t state
);

	int fail_count = 0;

	// A pending memory request may not move until the slave answers.
	property mem_req_held;
		@(posedge clk) disable iff (!arst_n)
		(mem_req.stb && !mem_resp.ack && !mem_resp.rty) |=>
			mem_req.stb && $stable(mem_req.adr) && $stable(mem_req.we) &&
			(!mem_req.we || $stable(mem_req.dat));
	endproperty

	cpu_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_resp.ack |-> (cpu_req.cyc && cpu_req.stb))
	else begin
		fail_count++;
		$error("CPU acknowledge outside an active bus cycle");
	end

	// The master ends its cycle right after the slave answers.
	mem_cycle_ends: assert property (@(posedge clk) disable iff (!arst_n)
		(mem_req.stb && (mem_resp.ack || mem_resp.rty)) |=> (!mem_req.cyc && !mem_req.stb))
	else begin
		fail_count++;
		$error("Memory cycle not ended after acknowledge or retry");
	end

	mem_req_stable: assert property (mem_req_held)
	else begin
		fail_count++;
		$error("Memory request changed before acknowledge or retry");
	end

	idle_in_reset: assert property (@(posedge clk)
		!arst_n |-> (state == lc3b_types::idle && !cpu_resp.ack && !mem_req.cyc && !mem_req.stb))
	else begin
		fail_count++;
		$error("Controller not idle with quiet buses during reset");
	end

endmodule: cache_sva

bind cache cache_sva i_sva (
	.clk(clk),
	.arst_n(arst_n),
	.cpu_req(cpu_req),
	.cpu_resp(cpu_resp),
	.mem_req(mem_req),
	.mem_resp(mem_resp),
	.state(i_control.state)
);

//--- cache_tb.sv
module cache_tb;

	localparam int timeout_cycles = 200;

	logic clk;
	logic arst_n;
	lc3b_types::wb_req_t cpu_req;
	lc3b_types::wb_resp_t cpu_resp;
	lc3b_types::wb_req_t mem_req;
	lc3b_types::wb_resp_t mem_resp;

	int error_count;
	int timeout_count;
	int assert_count;
	int tests_run;
	int fd;
	int status;
	int fields;
	logic timed_out;

	// One parsed line of the tests file.
	logic [8*200-1:0] text_line;
	logic [8*24-1:0] name;
	logic [7:0] op;
	lc3b_types::lc3b_line_addr adr;
	lc3b_types::lc3b_sel sel;
	lc3b_types::lc3b_line wdata;
	lc3b_types::lc3b_line expected;
	int accesses;

	cache #(.set_count(8)) i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.cpu_req(cpu_req),
		.cpu_resp(cpu_resp),
		.mem_req(mem_req),
		.mem_resp(mem_resp)
	);

	cache_mem_model i_mem (
		.clk(clk),
		.arst_n(arst_n),
		.req(mem_req),
		.resp(mem_resp)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(
		input logic [8*24-1:0] test_name,
		input logic [8*16-1:0] what,
		input logic [127:0] exp_value,
		input logic [127:0] act_value
	);
		if (act_value !== exp_value) begin
			error_count++;
			$display("Fail %0s %0s: expected %h, actual %h", test_name, what, exp_value, act_value);
		end
	endtask

	// Issues one CPU bus cycle and checks the data and the memory traffic it caused.
	task automatic run_op(
		input logic [8*24-1:0] test_name,
		input logic is_write,
		input lc3b_types::lc3b_line_addr line_adr,
		input lc3b_types::lc3b_sel byte_sel,
		input lc3b_types::lc3b_line write_data,
		input lc3b_types::lc3b_line exp_data,
		input int exp_accesses,
		output logic stuck
	);
		int start_count;
		int waited;
		@(posedge clk);
		#2;
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		cpu_req.we = is_write;
		cpu_req.adr = line_adr;
		cpu_req.sel = byte_sel;
		cpu_req.dat = write_data;
		start_count = i_mem.access_count;
		waited = 0;
		stuck = 1'b0;
		do begin
			@(negedge clk);
			waited++;
		end while (cpu_resp.ack !== 1'b1 && waited < timeout_cycles);
		if (cpu_resp.ack !== 1'b1) begin
			stuck = 1'b1;
			timeout_count++;
			$display("%0s: no CPU acknowledge within %0d cycles", test_name, timeout_cycles);
		end else begin
			if (!is_write)
				check_value(test_name, "read data", exp_data, cpu_resp.dat);
			check_value(test_name, "cpu rty", 0, cpu_resp.rty);
			check_value(test_name, "mem accesses", exp_accesses, i_mem.access_count - start_count);
			if (exp_accesses == 0)
				check_value(test_name, "hit latency", 2, waited - 1); // Cycles from strobe to ack.
		end
		@(posedge clk);
		#2;
		cpu_req = '0;
	endtask

	initial begin
		error_count = 0;
		timeout_count = 0;
		tests_run = 0;
		timed_out = 1'b0;
		cpu_req = '0;
		arst_n = 1'b0;
		repeat (15) @(posedge clk);
		@(negedge clk);
		check_value("in_reset", "cpu ack", 0, cpu_resp.ack);
		check_value("in_reset", "mem cyc", 0, mem_req.cyc);
		check_value("in_reset", "mem stb", 0, mem_req.stb);
		@(posedge clk);
		#2;
		arst_n = 1'b1;
		@(negedge clk);
		check_value("after_reset", "cpu ack", 0, cpu_resp.ack);
		check_value("after_reset", "mem cyc", 0, mem_req.cyc);
		check_value("after_reset", "mem stb", 0, mem_req.stb);

		fd = $fopen("cache_tests.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Could not open cache_tests.txt");
		end else begin
			while (!$feof(fd) && !timed_out) begin
				text_line = '0;
				status = $fgets(text_line, fd);
				fields = $sscanf(text_line, "%s %s %h %h %h %h %d",
					name, op, adr, sel, wdata, expected, accesses);
				if (status != 0 && fields == 7 && name != "#") begin
					run_op(name, op == "w", adr, sel, wdata, expected, accesses, timed_out);
					tests_run++;
				end
			end
			$fclose(fd);
			if (tests_run == 0) begin
				error_count++;
				$display("The tests file held no test entries");
			end
		end

		// Without a retry the reissue path of the controller went unused.
		if (i_mem.retry_count == 0) begin
			error_count++;
			$display("The memory model never issued a retry during the run");
		end

		assert_count = i_dut.i_sva.fail_count;
		$display("Ran %0d tests: %0d errors, %0d timeouts, %0d assertion failures",
			tests_run, error_count, timeout_count, assert_count);
		if (error_count == 0 && timeout_count == 0 && assert_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule: cache_tb

//--- cache_tests.txt
# name op(r/w) line_adr sel write_data expected_read_data mem_accesses
# All fields hex except mem_accesses. Write entries do not check read data.
first_read r 123 0000 0 01230123012301230123012301230123 1
repeat_read r 123 0000 0 01230123012301230123012301230123 0
read_b r 045 0000 0 00450045004500450045004500450045 1
write_b w 045 00f0 11112222333344445555666677778888 0 0
read_merged_b r 045 0000 0 00450045004500455555666600450045 0
read_c r 04d 0000 0 004d004d004d004d004d004d004d004d 1
evict_b r 055 0000 0 00550055005500550055005500550055 2
read_b_back r 045 0000 0 00450045004500455555666600450045 1
read_d_hit r 055 0000 0 00550055005500550055005500550055 0
read_b_way1 r 045 0000 0 00450045004500455555666600450045 0
write_miss_e w 2a1 8001 dead000000000000000000000000beef 0 1
read_e r 2a1 0000 0 dea102a102a102a102a102a102a102ef 0
read_f r 2a9 0000 0 02a902a902a902a902a902a902a902a9 1
evict_e r 2b1 0000 0 02b102b102b102b102b102b102b102b1 2
read_e_back r 2a1 0000 0 dea102a102a102a102a102a102a102ef 1
write_full w 123 ffff 0123456789abcdeffedcba9876543210 0 0
read_full r 123 0000 0 0123456789abcdeffedcba9876543210 0
read_h r fff 0000 0 0fff0fff0fff0fff0fff0fff0fff0fff 1
read_i r 800 0000 0 08000800080008000800080008000800 1
read_j r 803 0000 0 08030803080308030803080308030803 1
evict_full r 00b 0000 0 000b000b000b000b000b000b000b000b 2
read_full_back r 123 0000 0 0123456789abcdeffedcba9876543210 1

//--- all.f
lc3b_types.sv
cache_array.sv
cache_datapath.sv
cache_control.sv
cache.sv
cache_mem_model.sv
cache_sva.sv
cache_tb.sv
